// ==== Makefile ====
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -Mdir $(OBJ) -f build.f

run: compile
	./$(OBJ)/Vcpu_tb > sim.log 2>&1; cat sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf $(OBJ) sim.log

// ==== build.f ====
+incdir+design
design/isa_pkg.sv
design/bus_pkg.sv
design/alu.sv
design/decoder.sv
design/registers.sv
design/bus_wb8.sv
design/cpu.sv
sim/cpu_chk.sv
sim/cpu_tb.sv

// ==== design/alu.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu (
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  isa_pkg::alu_op_e op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    output logic [`CPU_XLEN-1:0] result,
    output logic busy,
    output logic lt,
    output logic ltu,
    output logic eq
);
    import isa_pkg::*;

    logic [4:0] shamt;    // remaining shift stages
    logic [4:0] step;
    alu_op_e shift_op;
    logic lt_s, lt_u;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    // lowest set bit of shamt, which is also the stage's shift distance
    assign step = shamt & (~shamt + 5'd1);
    assign busy = |shamt;

    always_ff @(posedge clk) begin
        if (reset) begin
            shamt <= '0;
        end else if (en) begin
            shamt <= (op inside {alu_sll, alu_srl, alu_sra}) ? b[4:0] : 5'd0;
        end else if (busy) begin
            shamt <= shamt & ~step;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            shift_op <= op;
            lt <= lt_s;
            ltu <= lt_u;
            eq <= (a == b);
            case (op)
                alu_sub:  result <= a - b;
                alu_slt:  result <= {{(`CPU_XLEN-1){1'b0}}, lt_s};
                alu_sltu: result <= {{(`CPU_XLEN-1){1'b0}}, lt_u};
                alu_xor:  result <= a ^ b;
                alu_or:   result <= a | b;
                alu_and:  result <= a & b;
                alu_sll, alu_srl, alu_sra: result <= a;    // shifted below
                default:  result <= a + b;
            endcase
        end else if (busy) begin
            case (shift_op)
                alu_sll: result <= result << step;
                alu_sra: result <= $signed(result) >>> step;
                default: result <= result >> step;
            endcase
        end
    end

endmodule

// ==== design/bus_pkg.sv ====
`include "cpu_consts.svh"

package bus_pkg;

    typedef enum logic [2:0] {
        bus_readb, bus_readbu, bus_readh, bus_readhu,
        bus_readw, bus_writeb, bus_writeh, bus_writew
    } bus_op_e;

    // master side of the 8-bit wishbone port
    typedef struct packed {
        logic [`CPU_XLEN-1:0] adr;
        logic [7:0] dat;
        logic cyc;
        logic stb;
        logic we;
    } wb_req_t;

    typedef struct packed {
        logic [7:0] dat;
        logic ack;
    } wb_rsp_t;

endpackage

// ==== design/bus_wb8.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module bus_wb8 (
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  bus_pkg::bus_op_e op,
    input  logic [`CPU_XLEN-1:0] addr,
    input  logic [`CPU_XLEN-1:0] wdata,
    output logic [`CPU_XLEN-1:0] rdata,
    output logic busy,
    output bus_pkg::wb_req_t wb_req,
    input  bus_pkg::wb_rsp_t wb_rsp
);
    import bus_pkg::*;

    typedef enum logic {
        idle,
        xfer
    } bus_state_e;

    bus_state_e state;
    logic [1:0] cnt;    // byte index within the access
    logic [1:0] last;
    logic is_write;
    bus_op_e op_q;
    logic [`CPU_XLEN-1:0] addr_q, wdata_q, rbuf;

    assign is_write = op_q inside {bus_writeb, bus_writeh, bus_writew};
    assign busy = (state == xfer);

    always_comb begin
        case (op_q)
            bus_readb, bus_readbu, bus_writeb: last = 2'd0;
            bus_readh, bus_readhu, bus_writeh: last = 2'd1;
            default: last = 2'd3;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            cnt <= '0;
        end else if (en) begin
            state <= xfer;
            cnt <= '0;
        end else if (state == xfer && wb_rsp.ack) begin
            if (cnt == last) begin
                state <= idle;    // cyc drops next cycle
            end else begin
                cnt <= cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            op_q <= op;
            addr_q <= addr;
            wdata_q <= wdata;
        end
        if (state == xfer && wb_rsp.ack && !is_write) begin
            rbuf <= {wb_rsp.dat, rbuf[`CPU_XLEN-1:8]};    // little-endian, fills from top
        end
    end

    always_comb begin
        wb_req.adr = addr_q + {30'b0, cnt};
        wb_req.dat = wdata_q[{cnt, 3'b000} +: 8];
        wb_req.cyc = (state == xfer);
        wb_req.stb = (state == xfer);
        wb_req.we = (state == xfer) && is_write;
    end

    // sign or zero extension of the assembled bytes
    always_comb begin
        case (op_q)
            bus_readb:  rdata = {{24{rbuf[31]}}, rbuf[31:24]};
            bus_readbu: rdata = {24'b0, rbuf[31:24]};
            bus_readh:  rdata = {{16{rbuf[31]}}, rbuf[31:16]};
            bus_readhu: rdata = {16'b0, rbuf[31:16]};
            default:    rdata = rbuf;
        endcase
    end

endmodule

// ==== design/cpu.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu (
    input  logic clk,
    input  logic reset,
    input  logic ack,
    input  logic [7:0] dat_i,
    output logic [`CPU_XLEN-1:0] adr,
    output logic [7:0] dat_o,
    output logic cyc,
    output logic stb,
    output logic we
);
    import isa_pkg::*;
    import bus_pkg::*;

    typedef enum logic {a_val1, a_pc} a_sel_e;
    typedef enum logic [1:0] {b_val2, b_imm, b_instlen} b_sel_e;
    typedef enum logic [1:0] {addr_pc, addr_alu, addr_target} addr_sel_e;
    typedef enum logic [1:0] {rd_alu, rd_bus, rd_imm} rd_sel_e;

    localparam logic [`CPU_XLEN-1:0] instlen = `CPU_INSTLEN;

    cpu_state_e state, next_state;
    logic [`CPU_XLEN-1:0] pc, instr, target;
    decoded_t dec;
    logic stall;

    logic alu_en, alu_busy, alu_lt, alu_ltu, alu_eq;
    alu_op_e alu_op;
    logic [`CPU_XLEN-1:0] alu_a, alu_b, alu_result;

    logic bus_en, bus_busy;
    bus_op_e bus_op;
    logic [`CPU_XLEN-1:0] bus_addr, bus_rdata;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    logic reg_re, reg_we;
    logic [`CPU_XLEN-1:0] reg_data, reg_val1, reg_val2;

    a_sel_e a_sel;
    b_sel_e b_sel;
    addr_sel_e addr_sel;
    rd_sel_e rd_sel;

    alu u_alu (
        .clk(clk), .reset(reset), .en(alu_en), .op(alu_op), .a(alu_a), .b(alu_b),
        .result(alu_result), .busy(alu_busy), .lt(alu_lt), .ltu(alu_ltu), .eq(alu_eq)
    );

    decoder u_decoder (.instr(instr), .dec(dec));

    registers u_registers (
        .clk(clk), .re(reg_re), .we(reg_we), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
        .data(reg_data), .val1(reg_val1), .val2(reg_val2)
    );

    bus_wb8 u_bus (
        .clk(clk), .reset(reset), .en(bus_en), .op(bus_op), .addr(bus_addr),
        .wdata(reg_val2), .rdata(bus_rdata), .busy(bus_busy),
        .wb_req(wb_req), .wb_rsp(wb_rsp)
    );

    assign adr = wb_req.adr;
    assign dat_o = wb_req.dat;
    assign cyc = wb_req.cyc;
    assign stb = wb_req.stb;
    assign we = wb_req.we;
    assign wb_rsp.dat = dat_i;
    assign wb_rsp.ack = ack;

    assign stall = alu_busy | bus_busy;
    assign target = {alu_result[`CPU_XLEN-1:1], 1'b0};    // jalr clears bit 0

    // operand and write-back selects
    assign alu_a = (a_sel == a_pc) ? pc : reg_val1;

    always_comb begin
        case (b_sel)
            b_imm:     alu_b = dec.imm;
            b_instlen: alu_b = instlen;
            default:   alu_b = reg_val2;
        endcase
        case (addr_sel)
            addr_alu:    bus_addr = alu_result;
            addr_target: bus_addr = target;
            default:     bus_addr = pc;
        endcase
        case (rd_sel)
            rd_bus:  reg_data = bus_rdata;
            rd_imm:  reg_data = dec.imm;
            default: reg_data = alu_result;
        endcase
    end

    function automatic alu_op_e funct_to_alu(input logic [2:0] funct3, input logic alt,
                                             input logic is_reg);
        alu_op_e r;
        case (alu_funct_e'(funct3))
            f_add:  r = (alt && is_reg) ? alu_sub : alu_add;    // no subi
            f_sll:  r = alu_sll;
            f_slt:  r = alu_slt;
            f_sltu: r = alu_sltu;
            f_xor:  r = alu_xor;
            f_srl:  r = alt ? alu_sra : alu_srl;
            f_or:   r = alu_or;
            default: r = alu_and;
        endcase
        return r;
    endfunction

    always_comb begin
        next_state = state;
        alu_en = 1'b0;
        alu_op = alu_add;
        bus_en = 1'b0;
        bus_op = bus_readw;
        reg_re = 1'b0;
        reg_we = 1'b0;
        a_sel = a_val1;
        b_sel = b_val2;
        addr_sel = addr_pc;
        rd_sel = rd_alu;

        case (state)
            st_reset: next_state = st_fetch;
            st_fetch: begin
                bus_en = 1'b1;
                next_state = st_decode;
            end
            st_decode: next_state = st_regread;    // instr latched on leaving
            st_regread: begin
                reg_re = 1'b1;
                case (dec.opcode)
                    opc_op:      next_state = st_op;
                    opc_opimm:   next_state = st_opimm;
                    opc_load:    next_state = st_load1;
                    opc_store:   next_state = st_store1;
                    opc_jal, opc_jalr: next_state = st_jal_jalr1;
                    opc_branch:  next_state = st_branch1;
                    opc_lui:     next_state = st_lui;
                    opc_auipc:   next_state = st_auipc;
                    opc_miscmem: next_state = st_pcnext;    // fence
                    default:     next_state = st_idle;
                endcase
            end
            st_op, st_opimm: begin
                alu_en = 1'b1;
                alu_op = funct_to_alu(dec.funct3, dec.funct7[5], state == st_op);
                b_sel = (state == st_op) ? b_val2 : b_imm;
                next_state = st_regwrite_alu;
            end
            st_load1, st_store1: begin    // effective address
                alu_en = 1'b1;
                b_sel = b_imm;
                next_state = (state == st_load1) ? st_load2 : st_store2;
            end
            st_load2: begin
                bus_en = 1'b1;
                addr_sel = addr_alu;
                case (mem_funct_e'(dec.funct3))
                    f_byte:  bus_op = bus_readb;
                    f_ubyte: bus_op = bus_readbu;
                    f_half:  bus_op = bus_readh;
                    f_uhalf: bus_op = bus_readhu;
                    default: bus_op = bus_readw;
                endcase
                next_state = st_regwrite_bus;
            end
            st_store2: begin
                bus_en = 1'b1;
                addr_sel = addr_alu;
                case (mem_funct_e'(dec.funct3))
                    f_byte:  bus_op = bus_writeb;
                    f_half:  bus_op = bus_writeh;
                    default: bus_op = bus_writew;
                endcase
                next_state = st_pcnext;
            end
            st_jal_jalr1, st_pcnext: begin    // pc + 4
                alu_en = 1'b1;
                a_sel = a_pc;
                b_sel = b_instlen;
                next_state = (state == st_pcnext) ? st_pcupdate_fetch : st_jal_jalr2;
            end
            st_jal_jalr2: begin
                reg_we = 1'b1;
                next_state = (dec.opcode == opc_jal) ? st_pcimm : st_pcregimm;
            end
            st_branch1: begin
                alu_en = 1'b1;    // flags only
                next_state = st_branch2;
            end
            st_branch2: begin
                case (branch_funct_e'(dec.funct3))
                    f_beq:   next_state = alu_eq ? st_pcimm : st_pcnext;
                    f_bne:   next_state = !alu_eq ? st_pcimm : st_pcnext;
                    f_blt:   next_state = alu_lt ? st_pcimm : st_pcnext;
                    f_bge:   next_state = !alu_lt ? st_pcimm : st_pcnext;
                    f_bltu:  next_state = alu_ltu ? st_pcimm : st_pcnext;
                    f_bgeu:  next_state = !alu_ltu ? st_pcimm : st_pcnext;
                    default: next_state = st_pcnext;
                endcase
            end
            st_lui: begin
                reg_we = 1'b1;
                rd_sel = rd_imm;
                next_state = st_pcnext;
            end
            st_auipc, st_pcimm: begin    // pc + imm
                alu_en = 1'b1;
                a_sel = a_pc;
                b_sel = b_imm;
                next_state = (state == st_auipc) ? st_regwrite_alu : st_pcupdate_fetch;
            end
            st_pcregimm: begin
                alu_en = 1'b1;
                b_sel = b_imm;
                next_state = st_pcupdate_fetch;
            end
            st_regwrite_bus, st_regwrite_alu: begin
                reg_we = 1'b1;
                rd_sel = (state == st_regwrite_bus) ? rd_bus : rd_alu;
                next_state = st_pcnext;
            end
            st_pcupdate_fetch: begin
                bus_en = 1'b1;
                addr_sel = addr_target;
                next_state = st_decode;
            end
            default: next_state = st_pcnext;    // st_idle, unknown opcode
        endcase

        // hold everything while a unit is busy
        if (stall) begin
            alu_en = 1'b0;
            bus_en = 1'b0;
            reg_re = 1'b0;
            reg_we = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_reset;
        end else if (!stall) begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            case (state)
                st_reset:          pc <= `CPU_RESET_PC;
                st_decode:         instr <= bus_rdata;
                st_pcupdate_fetch: pc <= target;
                default:           pc <= pc;
            endcase
        end
    end

endmodule

// ==== design/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// first fetch address
`define CPU_RESET_PC 32'h0000_0000

`define CPU_INSTLEN 4    // bytes per instruction

`define CPU_NREGS 32
`define CPU_XLEN 32

`endif

// ==== design/decoder.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decoder (
    input  logic [`CPU_XLEN-1:0] instr,
    output isa_pkg::decoded_t dec
);
    import isa_pkg::*;

    opcode_e opc;
    logic [`CPU_XLEN-1:0] imm;

    assign opc = opcode_e'(instr[6:2]);

    always_comb begin
        case (opc)
            opc_opimm, opc_load, opc_jalr:
                imm = {{20{instr[31]}}, instr[31:20]};
            opc_store:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            opc_branch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            opc_lui, opc_auipc:
                imm = {instr[31:12], 12'b0};
            opc_jal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;    // op, miscmem and unknown
        endcase
    end

    always_comb begin
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.rd = instr[11:7];
        dec.imm = imm;
        dec.opcode = opc;
        dec.funct3 = instr[14:12];
        dec.funct7 = instr[31:25];
    end

endmodule

// ==== design/isa_pkg.sv ====
`include "cpu_consts.svh"

package isa_pkg;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        opc_load = 5'b00000, opc_miscmem = 5'b00011, opc_opimm = 5'b00100,
        opc_auipc = 5'b00101, opc_store = 5'b01000, opc_op = 5'b01100,
        opc_lui = 5'b01101, opc_branch = 5'b11000, opc_jalr = 5'b11001,
        opc_jal = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // funct3 groups
    typedef enum logic [2:0] {
        f_add, f_sll, f_slt, f_sltu, f_xor, f_srl, f_or, f_and
    } alu_funct_e;

    typedef enum logic [2:0] {
        f_beq = 3'd0, f_bne = 3'd1, f_blt = 3'd4, f_bge = 3'd5, f_bltu = 3'd6, f_bgeu = 3'd7
    } branch_funct_e;

    typedef enum logic [2:0] {
        f_byte = 3'd0, f_half = 3'd1, f_word = 3'd2, f_ubyte = 3'd4, f_uhalf = 3'd5
    } mem_funct_e;    // same codes for loads and stores

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic [`CPU_XLEN-1:0] imm;
        opcode_e opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
    } decoded_t;

    typedef enum logic [4:0] {
        st_reset, st_fetch, st_decode, st_regread,
        st_jal_jalr1, st_jal_jalr2, st_lui, st_auipc, st_op, st_opimm,
        st_store1, st_store2, st_load1, st_load2, st_branch1, st_branch2,
        st_idle, st_regwrite_bus, st_regwrite_alu,
        st_pcnext, st_pcregimm, st_pcimm, st_pcupdate_fetch
    } cpu_state_e;

endpackage

// ==== design/registers.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module registers (
    input  logic clk,
    input  logic re,
    input  logic we,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [4:0] rd,
    input  logic [`CPU_XLEN-1:0] data,
    output logic [`CPU_XLEN-1:0] val1,
    output logic [`CPU_XLEN-1:0] val2
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin
            regs[rd] <= data;
        end
        if (re) begin
            val1 <= (rs1 == 5'd0) ? '0 : regs[rs1];    // x0 reads zero
            val2 <= (rs2 == 5'd0) ? '0 : regs[rs2];
        end
    end

endmodule

// ==== sim/cpu_chk.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_chk (
    input logic clk,
    input logic reset,
    input logic ack,
    input logic [`CPU_XLEN-1:0] adr,
    input logic [7:0] dat_o,
    input logic cyc,
    input logic stb,
    input logic we,
    input isa_pkg::cpu_state_e state
);
    import isa_pkg::*;

    a_stb_cyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
        else $error("stb high without cyc");

    a_hold: assert property (@(posedge clk) disable iff (reset)
        stb && !ack |=> $stable(adr) && $stable(we) && $stable(dat_o))
        else $error("bus request changed while waiting for ack");

    a_reset_idle: assert property (@(posedge clk) reset |=> !cyc && !stb && !we)
        else $error("bus not idle after reset");

    a_state: assert property (@(posedge clk) disable iff (reset) state <= st_pcupdate_fetch)
        else $error("state outside the state enum");

endmodule

bind cpu cpu_chk u_chk (
    .clk(clk), .reset(reset), .ack(ack), .adr(adr), .dat_o(dat_o),
    .cyc(cyc), .stb(stb), .we(we), .state(state)
);

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

    localparam int max_tests = 16;
    localparam int prog_len = 12;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic ack = 1'b0;
    logic [7:0] dat_i = 8'h00;
    logic [`CPU_XLEN-1:0] adr;
    logic [7:0] dat_o;
    logic cyc, stb, we;

    logic [7:0] mem [512];
    logic [31:0] rng = 32'hc9fb;
    logic [1:0] wait_cnt = 2'd0;
    int res_bytes, wr_count, errors, ntests, plen;
    bit table_ready;

    string names [max_tests];
    logic [31:0] prog [max_tests][prog_len];
    logic [31:0] expect_val [max_tests];
    int expect_wr [max_tests];

    always #2 clk = ~clk;

    cpu u_dut (
        .clk(clk), .reset(reset), .ack(ack), .dat_i(dat_i), .adr(adr),
        .dat_o(dat_o), .cyc(cyc), .stb(stb), .we(we)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // byte memory with 0..3 wait cycles per byte
    always @(posedge clk) begin
        if (ack) begin
            ack <= 1'b0;
        end else if (cyc && stb) begin
            if (wait_cnt == 2'd0) begin
                ack <= 1'b1;
                dat_i <= mem[adr[8:0]];
                if (we) begin
                    mem[adr[8:0]] <= dat_o;
                    if (adr[31:2] == 30'h40) begin    // 0x100..0x103
                        res_bytes <= res_bytes + 1;
                    end else begin
                        wr_count <= wr_count + 1;
                    end
                end
                rng = xorshift(rng);
                wait_cnt <= rng[1:0];
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    // instruction encoders
    function automatic logic [31:0] r_ins(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_ins(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] opc);
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] s_ins(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), f3, v[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_ins(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        logic [12:0] v;
        v = 13'(imm);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_ins(input int imm, input int rd);
        logic [20:0] v;
        v = 21'(imm);
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[ntests][plen] = w;
        plen++;
    endtask

    // every program stores x10 to 0x100 and spins
    task automatic close_entry(input string n, input logic [31:0] e, input int w);
        emit(s_ins(12'h100, 10, 0, 3'd2));
        emit(j_ins(0, 0));
        names[ntests] = n;
        expect_val[ntests] = e;
        expect_wr[ntests] = w;
        ntests++;
        plen = 0;
    endtask

    task automatic build_table();
        emit(i_ins(100, 0, 0, 1, 7'h13));
        emit(i_ins(-30, 0, 0, 2, 7'h13));
        emit(r_ins(7'h00, 2, 1, 0, 3));
        emit(r_ins(7'h20, 1, 2, 0, 10));
        close_entry("add_sub", 32'hffffff7e, 0);
        emit(i_ins(12'h5a5, 0, 0, 1, 7'h13));
        emit(i_ins(12'h0ff, 1, 4, 2, 7'h13));
        emit(i_ins(12'h0f0, 2, 6, 3, 7'h13));
        emit(i_ins(12'h3cc, 3, 7, 10, 7'h13));
        close_entry("logic_imm", 32'h000001c8, 0);
        emit(i_ins(-1, 0, 0, 1, 7'h13));
        emit(i_ins(1, 0, 0, 2, 7'h13));
        emit(r_ins(7'h00, 2, 1, 2, 3));
        emit(r_ins(7'h00, 2, 1, 3, 4));
        emit(i_ins(2, 2, 3, 5, 7'h13));
        emit(i_ins(2, 3, 1, 3, 7'h13));
        emit(r_ins(7'h00, 5, 3, 0, 10));
        emit(r_ins(7'h00, 4, 10, 0, 10));
        close_entry("slt_sltu", 32'h00000005, 0);
        emit({20'h80000, 5'd1, 7'b0110111});
        emit(i_ins(12'h41f, 1, 5, 2, 7'h13));
        emit(i_ins(31, 1, 5, 3, 7'h13));
        emit(i_ins(31, 3, 1, 4, 7'h13));
        emit(i_ins(12'h401, 1, 5, 5, 7'h13));
        emit(i_ins(0, 5, 1, 6, 7'h13));
        emit(r_ins(7'h00, 2, 6, 4, 10));
        emit(r_ins(7'h00, 3, 10, 0, 10));
        emit(r_ins(7'h00, 4, 10, 4, 10));
        close_entry("shifts", 32'hc0000000, 0);
        emit(i_ins(12'h80, 0, 0, 1, 7'h03));
        emit(i_ins(12'h80, 0, 4, 2, 7'h03));
        emit(i_ins(12'h80, 0, 1, 3, 7'h03));
        emit(i_ins(12'h80, 0, 5, 4, 7'h03));
        emit(i_ins(12'h80, 0, 2, 5, 7'h03));
        emit(r_ins(7'h00, 2, 1, 0, 10));
        emit(r_ins(7'h00, 3, 10, 0, 10));
        emit(r_ins(7'h00, 4, 10, 0, 10));
        emit(r_ins(7'h00, 5, 10, 0, 10));
        close_entry("loads", 32'h4434d785, 0);
        emit(i_ins(-3, 0, 0, 1, 7'h13));
        emit(s_ins(12'h90, 1, 0, 2));
        emit(i_ins(12'h12, 0, 0, 2, 7'h13));
        emit(s_ins(12'h91, 2, 0, 0));
        emit(i_ins(12'h345, 0, 0, 3, 7'h13));
        emit(s_ins(12'h92, 3, 0, 1));
        emit(i_ins(12'h90, 0, 2, 10, 7'h03));
        close_entry("stores", 32'h034512fd, 7);    // 4 + 1 + 2 strobes
        emit(i_ins(0, 0, 0, 10, 7'h13));
        emit(i_ins(-1, 0, 0, 1, 7'h13));
        emit(i_ins(1, 0, 0, 2, 7'h13));
        emit(b_ins(8, 2, 1, 4));
        emit(i_ins(1, 10, 0, 10, 7'h13));
        emit(b_ins(8, 2, 1, 6));
        emit(i_ins(2, 10, 0, 10, 7'h13));
        emit(b_ins(8, 2, 1, 5));
        emit(i_ins(4, 10, 0, 10, 7'h13));
        close_entry("branch_signed", 32'h00000006, 0);
        emit(i_ins(0, 0, 0, 10, 7'h13));
        emit(i_ins(5, 0, 0, 1, 7'h13));
        emit(b_ins(8, 1, 1, 0));
        emit(i_ins(1, 10, 0, 10, 7'h13));
        emit(b_ins(8, 1, 1, 1));
        emit(i_ins(2, 10, 0, 10, 7'h13));
        emit(b_ins(8, 0, 1, 7));
        emit(i_ins(4, 10, 0, 10, 7'h13));
        close_entry("branch_eq", 32'h00000002, 0);
        // operands swapped, opposite outcomes
        emit(i_ins(0, 0, 0, 10, 7'h13));
        emit(i_ins(-1, 0, 0, 1, 7'h13));
        emit(i_ins(1, 0, 0, 2, 7'h13));
        emit(b_ins(8, 1, 2, 4));
        emit(i_ins(1, 10, 0, 10, 7'h13));
        emit(b_ins(8, 1, 2, 6));
        emit(i_ins(2, 10, 0, 10, 7'h13));
        emit(b_ins(8, 1, 2, 5));
        emit(i_ins(4, 10, 0, 10, 7'h13));
        close_entry("branch_signed_rev", 32'h00000001, 0);
        emit(i_ins(0, 0, 0, 10, 7'h13));
        emit(i_ins(5, 0, 0, 1, 7'h13));
        emit(b_ins(8, 0, 1, 0));
        emit(i_ins(1, 10, 0, 10, 7'h13));
        emit(b_ins(8, 0, 1, 1));
        emit(i_ins(2, 10, 0, 10, 7'h13));
        emit(b_ins(8, 1, 0, 7));
        emit(i_ins(4, 10, 0, 10, 7'h13));
        close_entry("branch_eq_rev", 32'h00000005, 0);
        emit(j_ins(8, 1));
        emit(i_ins(12'h7ff, 0, 0, 1, 7'h13));    // jumped over
        emit(i_ins(24, 0, 0, 3, 7'h13));
        emit(i_ins(1, 3, 0, 2, 7'h67));    // odd target
        emit(i_ins(1, 0, 0, 2, 7'h13));
        emit(i_ins(2, 0, 0, 2, 7'h13));
        emit(i_ins(8, 1, 1, 1, 7'h13));
        emit(r_ins(7'h00, 2, 1, 6, 10));
        close_entry("jal_jalr", 32'h00000410, 0);
        emit({20'h12345, 5'd1, 7'b0110111});
        emit({20'h00001, 5'd2, 7'b0010111});
        emit(32'h0ff0000f);
        emit(r_ins(7'h00, 2, 1, 0, 10));
        close_entry("lui_auipc_fence", 32'h12346004, 0);
    endtask

    initial begin
        logic [31:0] got;
        build_table();
        table_ready = 1'b1;
        for (int t = 0; t < ntests; t++) begin
            for (int a = 0; a < 512; a++) begin
                mem[a] = 8'h00;
            end
            for (int i = 0; i < prog_len; i++) begin
                {mem[4*i+3], mem[4*i+2], mem[4*i+1], mem[4*i]} = prog[t][i];
            end
            {mem[9'h83], mem[9'h82], mem[9'h81], mem[9'h80]} = 32'h4433f281;    // load data
            res_bytes = 0;
            wr_count = 0;
            repeat (5) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            while (!stb) @(negedge clk);
            assert (adr == `CPU_RESET_PC && !we) else begin
                errors++;
                $display("Mismatch %s first fetch: expected %h read, actual %h we %b",
                         names[t], `CPU_RESET_PC, adr, we);
            end
            while (res_bytes == 0) @(negedge clk);
            while (cyc) @(negedge clk);
            got = {mem[9'h103], mem[9'h102], mem[9'h101], mem[9'h100]};
            assert (got == expect_val[t]) else begin
                errors++;
                $display("Mismatch %s: expected %h, actual %h", names[t], expect_val[t], got);
            end
            assert (wr_count == expect_wr[t]) else begin
                errors++;
                $display("Mismatch %s write strobes: expected %0d, actual %0d",
                         names[t], expect_wr[t], wr_count);
            end
            @(posedge clk);
            reset <= 1'b1;    // next entry starts from reset
        end
        $display("%0d tests run, %0d errors", ntests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(ntests * 2000 * 4);
        $display("watchdog expired, the core never stored its result");
        $display("TEST FAIL");
        $finish;
    end

endmodule
